//--- hw/cpu_config.svh
// build-time sizing for the cpu, included by the package and by the blocks that size storage
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// program store
////////////////////////////////////////////////////////////////////////////

// instruction words in the rom
// 8 bit load and fetch addresses cover all of it
`define CPU_ROM_DEPTH 256

////////////////////////////////////////////////////////////////////////////
// uart transmit
////////////////////////////////////////////////////////////////////////////

// beats allowed in flight before the receiver must hand credits back
`define CPU_UART_CREDITS 2

////////////////////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////////////////////

`define CPU_DATA_W 8 // a, b, alu and uart byte

`endif

//--- hw/cpu_pkg.sv
// shared types for the cpu: instruction fields, the instruction word and the uart beat
`include "cpu_config.svh"

package cpu_pkg;

    // where the alu result goes
    typedef enum logic [3:0] {
        tgt_rega     = 4'd0,
        tgt_regb     = 4'd1,
        tgt_pclo     = 4'd2, // loads pc from {pchitmp, result}
        tgt_pchitmp  = 4'd3, // stages the high byte of a far jump
        tgt_pc       = 4'd4, // 16 bit jump, uses the jump view
        tgt_uart     = 4'd5,
        tgt_halt     = 4'd6,
        tgt_not_used = 4'd7  // no write, alu and flags only
    } target_e;

    typedef enum logic [2:0] {
        src_a     = 3'd0,
        src_b     = 3'd1,
        src_immed = 3'd2,
        src_zero  = 3'd3
    } source_e;

    typedef enum logic [3:0] {
        op_pass_a = 4'd0, // first operand
        op_pass_b = 4'd1, // second operand
        op_add    = 4'd2,
        op_sub    = 4'd3, // carry is borrow
        op_and    = 4'd4,
        op_or     = 4'd5,
        op_xor    = 4'd6,
        op_inc    = 4'd7  // first operand + 1
    } alu_op_e;

    typedef enum logic [2:0] {
        cond_always = 3'd0,
        cond_z      = 3'd1,
        cond_nz     = 3'd2,
        cond_c      = 3'd3,
        cond_nc     = 3'd4
    } cond_e;

    // alu form of the word, used by every target except pc
    typedef struct packed {
        target_e     target;
        cond_e       cond;
        source_e     srca;
        source_e     srcb;
        alu_op_e     op;
        logic        set_flags;
        logic [7:0]  immed8;
        logic [21:0] pad;
    } alu_view_t;

    // jump form, same target and cond bits up front
    typedef struct packed {
        target_e     target;
        cond_e       cond;
        logic [15:0] immed16;
        logic [24:0] pad;
    } jump_view_t;

    typedef union packed {
        alu_view_t  alu;
        jump_view_t jmp;
    } instr_u; // 48 bits either way

    typedef struct packed {
        logic                   valid;
        logic [`CPU_DATA_W-1:0] data;
    } uart_beat_t;

endpackage

//--- hw/program_rom.sv
// instruction store; written by the loader during reset, read once per cycle at the pc
`include "cpu_config.svh"

module program_rom import cpu_pkg::*; (
    input  logic       clk,
    input  logic       load_we,
    input  logic [7:0] load_addr,
    input  instr_u     load_word,
    input  logic [7:0] rd_addr,
    output instr_u     rd_word
);

    instr_u mem [`CPU_ROM_DEPTH]; // no init, unwritten words stay X

    // set by the first loader write
    // before that every word is X and the pc reads are expected garbage
    logic armed = 1'b0;

    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_word;
            armed          <= 1'b1;
        end
        rd_word <= mem[rd_addr]; // registered read, word valid the next cycle
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // pc ran into a word that was never loaded
    // usually a missing halt or a bad jump target
    a_no_x_fetch: assert property (
        @(posedge clk) (armed && !load_we) |-> !$isunknown(mem[rd_addr])
    ) else $error("program word at %0d is X", rd_addr);

endmodule

//--- hw/cpu_ctrl.sv
// two phase sequencer and decoder; turns the current word into one set of enables per instruction
module cpu_ctrl import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  instr_u  instr,
    input  logic    flag_z,
    input  logic    flag_c,
    input  logic    can_send,
    output logic    exec,       // 0 fetch, 1 exec
    output logic    wr_a,
    output logic    wr_b,
    output logic    wr_pchitmp,
    output logic    pc_jump16,  // pc <= immed16
    output logic    pc_jump_lo, // pc <= {pchitmp, result}
    output logic    pc_inc,
    output logic    uart_wr,
    output logic    halted,
    output source_e srca,
    output source_e srcb,
    output alu_op_e op,
    output logic    set_flags
);

    target_e tgt;
    logic    cond_ok;
    logic    active;    // exec with a true condition
    logic    stall;     // uart write waiting on a credit
    logic    halt_fire;

    assign tgt = instr.alu.target; // same bits in the jump view

    always_comb begin
        case (instr.alu.cond)
            cond_always: cond_ok = 1'b1;
            cond_z:      cond_ok = flag_z;
            cond_nz:     cond_ok = !flag_z;
            cond_c:      cond_ok = flag_c;
            cond_nc:     cond_ok = !flag_c;
            default:     cond_ok = 1'b0; // unused codes never execute
        endcase
    end

    assign active    = exec && cond_ok;
    assign stall     = active && (tgt == tgt_uart) && !can_send;
    assign halt_fire = active && (tgt == tgt_halt);

    // target decode, at most one of these per exec cycle
    assign wr_a       = active && (tgt == tgt_rega);
    assign wr_b       = active && (tgt == tgt_regb);
    assign wr_pchitmp = active && (tgt == tgt_pchitmp);
    assign pc_jump16  = active && (tgt == tgt_pc);
    assign pc_jump_lo = active && (tgt == tgt_pclo);
    assign uart_wr    = active && (tgt == tgt_uart) && can_send;

    // falls through on everything else, false conditions included
    // halt leaves pc parked on the halt word
    assign pc_inc = exec && !stall && !halt_fire && !pc_jump16 && !pc_jump_lo;

    // flag bits overlap immed16 in the jump view so pc never sets flags
    assign set_flags = active && !stall && (tgt != tgt_pc) && instr.alu.set_flags;

    assign srca = instr.alu.srca;
    assign srcb = instr.alu.srcb;
    assign op   = instr.alu.op;

    always_ff @(posedge clk) begin
        if (rst) begin
            exec   <= 1'b0;
            halted <= 1'b0;
        end else begin
            if (halt_fire) begin
                halted <= 1'b1; // sticky until reset
            end
            if (exec) begin
                exec <= stall; // hold exec until the credit shows up
            end else begin
                exec <= !halted;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // pc moves once per instruction
    // an update is always followed by a fetch cycle
    a_one_pc_update: assert property (
        @(posedge clk) disable iff (rst)
        (pc_jump16 || pc_jump_lo || pc_inc) |=> !(pc_jump16 || pc_jump_lo || pc_inc)
    );

    // once stopped, the sequencer stays parked with nothing firing
    a_halt_quiet: assert property (
        @(posedge clk) disable iff (rst)
        halted |=> (halted && !exec && !uart_wr && !set_flags)
    );

endmodule

//--- hw/cpu_alu.sv
// combinational alu: operand select, 8 bit result, carry out and zero flag
module cpu_alu import cpu_pkg::*; (
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic [7:0] immed,
    input  source_e    srca,
    input  source_e    srcb,
    input  alu_op_e    op,
    output logic [7:0] result,
    output logic       carry,
    output logic       zero
);

    logic [7:0] x; // first operand
    logic [7:0] y; // second operand
    logic [8:0] wide; // result with carry in bit 8

    // one mux shared by both operand ports
    function automatic logic [7:0] pick(source_e sel, logic [7:0] ra, logic [7:0] rb,
                                        logic [7:0] im);
        logic [7:0] v;
        case (sel)
            src_a:     v = ra;
            src_b:     v = rb;
            src_immed: v = im;
            default:   v = 8'h00; // src_zero and spare codes
        endcase
        return v;
    endfunction

    assign x = pick(srca, a, b, immed);
    assign y = pick(srcb, a, b, immed);

    always_comb begin
        case (op)
            op_pass_a: wide = {1'b0, x};
            op_pass_b: wide = {1'b0, y};
            op_add:    wide = {1'b0, x} + {1'b0, y};
            op_sub:    wide = {1'b0, x} - {1'b0, y}; // bit 8 set on borrow
            op_and:    wide = {1'b0, x & y};
            op_or:     wide = {1'b0, x | y};
            op_xor:    wide = {1'b0, x ^ y};
            op_inc:    wide = {1'b0, x} + 9'd1;
            default:   wide = 9'h000;
        endcase
    end

    assign result = wide[7:0];
    assign carry  = wide[8];
    assign zero   = (wide[7:0] == 8'h00);

endmodule

//--- hw/uart_credit_tx.sv
// uart transmit side: credit counter plus one parallel byte beat per accepted write
`include "cpu_config.svh"

module uart_credit_tx import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  logic [7:0] data,
    input  logic       credit_ret, // one pulse per credit handed back
    output logic       can_send,
    output uart_beat_t tx
);

    localparam int unsigned MAX_CRED = `CPU_UART_CREDITS;
    localparam int CRED_W = $clog2(MAX_CRED + 1);

    logic [CRED_W-1:0] credits;
    logic              accept;

    assign can_send = (credits != '0);
    assign accept   = wr && can_send;

    // beat goes out in the same cycle as the write, no buffering
    assign tx.valid = accept;
    assign tx.data  = data;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(MAX_CRED);
        end else begin
            case ({accept, credit_ret})
                2'b10:   credits <= credits - 1'b1; // sent
                2'b01:   credits <= credits + 1'b1; // returned
                default: credits <= credits;        // both or neither
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // ctrl must already have stalled the write when the pool is empty
    a_wr_has_credit: assert property (
        @(posedge clk) disable iff (rst) wr |-> can_send
    );

    // receiver hands back more than was ever sent
    a_no_over_return: assert property (
        @(posedge clk) disable iff (rst)
        (credit_ret && !accept) |-> (credits < CRED_W'(MAX_CRED))
    );

    // counter never leaves 0 to MAX_CRED
    // a send from an empty pool wraps and lands above the top
    a_count_range: assert property (
        @(posedge clk) disable iff (rst) credits <= CRED_W'(MAX_CRED)
    );

endmodule

//--- hw/cpu.sv
// cpu top level: register file, pc and flags around the rom, sequencer, alu and uart port
module cpu import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_we,   // loader, only while rst is high
    input  logic [7:0] load_addr,
    input  instr_u     load_word,
    input  logic       credit_ret,
    output uart_beat_t tx,
    output logic       halted
);

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] pchitmp; // high byte waiting for the pclo write
    logic [7:0] pchi;
    logic [7:0] pclo;
    logic       flag_z;
    logic       flag_c;

    instr_u     instr; // word fetched at pc

    // sequencer outputs
    logic       exec;
    logic       wr_a;
    logic       wr_b;
    logic       wr_pchitmp;
    logic       pc_jump16;
    logic       pc_jump_lo;
    logic       pc_inc;
    logic       uart_wr;
    logic       set_flags;
    source_e    srca;
    source_e    srcb;
    alu_op_e    op;

    // alu outputs
    logic [7:0] result;
    logic       carry;
    logic       zero;

    logic       can_send;

    ////////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////////

    program_rom u_rom (
        .clk       (clk),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_word (load_word),
        .rd_addr   (pclo),      // 256 words so the low byte is enough
        .rd_word   (instr)
    );

    cpu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .flag_z     (flag_z),
        .flag_c     (flag_c),
        .can_send   (can_send),
        .exec       (exec),
        .wr_a       (wr_a),
        .wr_b       (wr_b),
        .wr_pchitmp (wr_pchitmp),
        .pc_jump16  (pc_jump16),
        .pc_jump_lo (pc_jump_lo),
        .pc_inc     (pc_inc),
        .uart_wr    (uart_wr),
        .halted     (halted),
        .srca       (srca),
        .srcb       (srcb),
        .op         (op),
        .set_flags  (set_flags)
    );

    cpu_alu u_alu (
        .a      (a),
        .b      (b),
        .immed  (instr.alu.immed8),
        .srca   (srca),
        .srcb   (srcb),
        .op     (op),
        .result (result),
        .carry  (carry),
        .zero   (zero)
    );

    uart_credit_tx u_uart (
        .clk        (clk),
        .rst        (rst),
        .wr         (uart_wr),
        .data       (result),   // byte is whatever the alu produced
        .credit_ret (credit_ret),
        .can_send   (can_send),
        .tx         (tx)
    );

    ////////////////////////////////////////////////////////////////////////////
    // register writes, all on the exec edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            {pchi, pclo} <= 16'h0000;
            flag_z       <= 1'b0;
            flag_c       <= 1'b0;
        end else begin
            if (pc_jump16) begin
                {pchi, pclo} <= instr.jmp.immed16;
            end else if (pc_jump_lo) begin
                {pchi, pclo} <= {pchitmp, result}; // far jump completes here
            end else if (pc_inc) begin
                {pchi, pclo} <= {pchi, pclo} + 16'd1;
            end
            if (set_flags) begin
                flag_z <= zero;
                flag_c <= carry;
            end
        end
    end

    // data registers and the far jump high byte
    always_ff @(posedge clk) begin
        if (wr_a) a <= result;
        if (wr_b) b <= result;
        if (wr_pchitmp) pchitmp <= result;
    end

    // pc only moves on an exec edge, never during fetch
    a_pc_holds_in_fetch: assert property (
        @(posedge clk) disable iff (rst) !exec |=> $stable({pchi, pclo})
    );

endmodule

//--- test/cpu_checker.sv
// scoreboard for the cpu testbench: compares uart beats with expected bytes and tracks credits
`include "cpu_config.svh"

module cpu_checker import cpu_pkg::*; (
    input logic       clk,
    input logic       rst,
    input uart_beat_t tx,
    input logic       halted,
    input logic       credit_ret
);
    timeunit 1ns;
    timeprecision 1ps;

    string      test_name;
    logic [7:0] exp_q[$];   // bytes still owed by the dut
    int         errors;     // within the current test
    int         passed = 0;
    int         failed = 0;
    int         outstanding; // beats sent, credit not yet back
    logic       seen_halt;

    ////////////////////////////////////////////////////////////////////////////
    // per test bookkeeping, called from the testbench top
    ////////////////////////////////////////////////////////////////////////////

    task automatic begin_test(input string name);
        test_name = name;
        exp_q.delete();
        errors = 0;
    endtask

    task automatic expect_byte(input logic [7:0] value);
        exp_q.push_back(value);
    endtask

    task automatic end_test();
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected bytes never arrived", test_name, exp_q.size());
            errors++;
        end
        if (errors == 0) begin
            $display("PASS %s", test_name);
            passed++;
        end else begin
            $display("FAIL %s (%0d errors)", test_name, errors);
            failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // beat and credit monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : watch
        logic [7:0] want;
        if (rst) begin
            outstanding = 0;
            seen_halt   = 1'b0;
        end else begin
            if (credit_ret) outstanding--;
            if (tx.valid) outstanding++;
            if (outstanding > `CPU_UART_CREDITS) begin
                $display("%s: %0d beats outstanding, only %0d credits exist",
                         test_name, outstanding, `CPU_UART_CREDITS);
                errors++;
            end
            if (tx.valid) begin
                if (seen_halt) begin
                    $display("%s: beat %02h sent after halt", test_name, tx.data);
                    errors++;
                end else if (exp_q.size() == 0) begin
                    $display("%s: extra byte %02h beyond the expected ones",
                             test_name, tx.data);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (tx.data !== want) begin
                        $display("MISMATCH %s: expected %02h actual %02h",
                                 test_name, want, tx.data);
                        errors++;
                    end
                end
            end
            if (seen_halt && halted !== 1'b1) begin // sticky until reset
                $display("%s: halted dropped before reset", test_name);
                errors++;
            end
            if (halted === 1'b1) seen_halt = 1'b1;
        end
    end

endmodule

//--- test/tb_cpu.sv
// cpu testbench top: reads the cases file, loads each program in reset, runs it, returns credits
module tb_cpu import cpu_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    logic       clk = 1'b0;
    logic       rst;
    logic       load_we;
    logic [7:0] load_addr;
    instr_u     load_word;
    logic       credit_ret = 1'b0;
    uart_beat_t tx;
    logic       halted;

    // cases file contents, flattened
    string       names[$];
    int          delays[$];
    int          first_w[$];
    int          n_w[$];
    int          first_e[$];
    int          n_e[$];
    logic [7:0]  waddr[$];
    logic [47:0] wdata[$];
    logic [7:0]  ebytes[$];

    int   seed;
    int   cur_delay;
    int   cycle = 0;
    int   due[$];    // cycle at which each pending credit goes back
    int   limit = 0; // watchdog budget in cycles, 0 until known

    always #10 clk = ~clk;

    cpu u_cpu (
        .clk        (clk),
        .rst        (rst),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_word  (load_word),
        .credit_ret (credit_ret),
        .tx         (tx),
        .halted     (halted)
    );

    cpu_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .tx         (tx),
        .halted     (halted),
        .credit_ret (credit_ret)
    );

    ////////////////////////////////////////////////////////////////////////////
    // word packing, field order as in the instruction format
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [47:0] alu_word(input logic [3:0] tgt, input logic [2:0] cond,
                                             input logic [2:0] sa, input logic [2:0] sb,
                                             input logic [3:0] op, input logic sf,
                                             input logic [7:0] imm);
        return {tgt, cond, sa, sb, op, sf, imm, 22'd0};
    endfunction

    function automatic logic [47:0] jump_word(input logic [2:0] cond, input logic [15:0] dest);
        return {4'd4, cond, dest, 25'd0}; // target pc
    endfunction

    task automatic read_cases();
        int          fd;
        int          rc;
        int          last;
        string       tok;
        string       line;
        string       nm;
        int          ad;
        int          tg;
        int          cd;
        int          sa;
        int          sb;
        int          op;
        int          sf;
        int          dly;
        logic [7:0]  im;
        logic [15:0] im16;
        fd = $fopen("test/cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/cpu_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fscanf(fd, "%s", tok);
                if (rc != 1) break;
                last = names.size() - 1;
                if (tok == "#") begin
                    rc = $fgets(line, fd); // rest of a comment line
                end else if (tok == "test") begin
                    rc = $fscanf(fd, "%s %d", nm, dly);
                    names.push_back(nm);
                    delays.push_back(dly);
                    first_w.push_back(wdata.size());
                    n_w.push_back(0);
                    first_e.push_back(ebytes.size());
                    n_e.push_back(0);
                end else if (tok == "i") begin
                    rc = $fscanf(fd, "%d %d %d %d %d %d %d %h", ad, tg, cd, sa, sb, op, sf, im);
                    waddr.push_back(ad[7:0]);
                    wdata.push_back(alu_word(tg, cd, sa, sb, op, sf[0], im));
                    n_w[last] = n_w[last] + 1;
                end else if (tok == "j") begin
                    rc = $fscanf(fd, "%d %d %h", ad, cd, im16);
                    waddr.push_back(ad[7:0]);
                    wdata.push_back(jump_word(cd, im16));
                    n_w[last] = n_w[last] + 1;
                end else if (tok == "e") begin
                    rc = $fscanf(fd, "%h", im);
                    ebytes.push_back(im);
                    n_e[last] = n_e[last] + 1;
                end else if (tok != "end") begin
                    $display("unknown token '%s' in cases file", tok);
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // credit return, one pulse per beat after the test's delay
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : beat_track
        int dly;
        if (!rst && tx.valid) begin
            dly = (cur_delay < 0) ? int'($unsigned($random(seed)) % 8) : cur_delay;
            due.push_back(cycle + dly + 1);
        end
    end

    always @(negedge clk) begin
        cycle++;
        if (due.size() > 0 && due[0] <= cycle) begin // one pulse per cycle at most
            credit_ret = 1'b1;
            due.delete(0);
        end else begin
            credit_ret = 1'b0;
        end
    end

    task automatic run_test(input int t);
        @(negedge clk);
        rst       = 1'b1;
        cur_delay = delays[t];
        u_checker.begin_test(names[t]);
        for (int k = 0; k < n_e[t]; k++) u_checker.expect_byte(ebytes[first_e[t] + k]);
        for (int k = 0; k < n_w[t]; k++) begin // loader, one word per cycle
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = waddr[first_w[t] + k];
            load_word = wdata[first_w[t] + k];
        end
        @(negedge clk);
        load_we = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (halted !== 1'b1) @(negedge clk);
        repeat (10) @(negedge clk); // halted must hold, no late beats
        while (due.size() != 0) @(negedge clk);
        u_checker.end_test();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst       = 1'b1;
        load_we   = 1'b0;
        load_addr = 8'd0;
        load_word = '0;
        seed      = 32'hf7e64d5c;
        cur_delay = 0;
        read_cases();
        limit = 100 + 2 * wdata.size() + 10 * ebytes.size();
        for (int t = 0; t < names.size(); t++) run_test(t);
        $display("tests passed %0d, failed %0d", u_checker.passed, u_checker.failed);
        if (u_checker.failed == 0 && names.size() > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (limit > 0);
        #(limit * 20);
        $display("timeout after %0d cycles in test %s", limit, u_checker.test_name);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/cpu_pkg.sv
hw/program_rom.sv
hw/cpu_ctrl.sv
hw/cpu_alu.sv
hw/uart_credit_tx.sv
hw/cpu.sv
test/cpu_checker.sv
test/tb_cpu.sv

//--- test/cpu_cases.txt
# per test: test <name> <credit delay, -1 random>, then i/j program words, e bytes, end
# i <addr> <target> <cond> <srca> <srcb> <op> <set_flags> <immed8 hex>   j <addr> <cond> <immed16 hex>
test imm_uart 0
i 0 0 0 2 3 0 0 5a
i 1 5 0 0 3 0 0 00
i 2 6 0 0 0 0 0 00
e 5a
end
test alu_ops 1
i 0 0 0 2 3 0 0 c8
i 1 1 0 2 3 0 0 64
i 2 5 0 0 1 2 0 00
i 3 5 0 1 0 3 0 00
i 4 5 0 0 1 6 0 00
i 5 5 0 0 3 7 0 00
i 6 6 0 0 0 0 0 00
e 2c
e 9c
e ac
e c9
end
test count_loop 2
i 0 0 0 2 3 0 0 03
i 1 5 0 0 3 0 0 00
i 2 0 0 0 2 3 1 01
j 3 2 0001
i 4 6 0 0 0 0 0 00
e 03
e 02
e 01
end
test cond_flags -1
i 0 0 0 2 3 0 0 ff
i 1 7 0 0 2 2 1 01
j 2 3 0004
i 3 5 0 2 3 0 0 11
i 4 5 0 2 3 0 0 22
j 5 2 0007
i 6 5 0 2 3 0 0 33
i 7 7 0 0 2 3 1 01
j 8 3 000a
i 9 5 0 2 3 0 0 44
j 10 2 000c
i 11 5 0 2 3 0 0 55
i 12 5 0 2 3 0 0 66
i 13 6 0 0 0 0 0 00
e 22
e 33
e 44
e 66
end
test far_jump 0
i 0 3 0 2 3 0 0 00
i 1 2 0 2 3 0 0 0a
i 2 5 0 2 3 0 0 11
i 10 5 0 2 3 0 0 77
j 11 0 003c
i 12 5 0 2 3 0 0 88
i 60 5 0 2 3 0 0 99
i 61 6 0 0 0 0 0 00
e 77
e 99
end
test slow_credit 7
i 0 5 0 2 3 0 0 01
i 1 5 0 2 3 0 0 02
i 2 5 0 2 3 0 0 03
i 3 5 0 2 3 0 0 04
i 4 5 0 2 3 0 0 05
i 5 6 0 0 0 0 0 00
e 01
e 02
e 03
e 04
e 05
end
